// File: common/aes_defs.svh
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// stream side word width
`define AES_WORD_W 32

// one AES block
`define AES_BLOCK_W 128

// AES-128 round count
`define AES_ROUNDS 10

// block entries per FIFO
`define AES_FIFO_DEPTH 16

`endif

// File: common/aes_pkg.sv
`include "aes_defs.svh"

package aes_pkg;

	typedef logic [`AES_WORD_W-1:0] word_t;
	typedef logic [`AES_BLOCK_W-1:0] block_t;
	typedef logic [`AES_BLOCK_W-1:0] key_t;
	typedef logic [7:0] byte_t;
	typedef logic [3:0] round_t;

	// stream slave packet parser
	typedef enum logic [1:0] {
		S_CMD,
		S_KEY,
		S_IV,
		S_DATA
	} hdr_state_t;

	// block sequencer
	typedef enum logic [1:0] {
		C_IDLE,
		C_FETCH,
		C_RUN,
		C_PUSH
	} ctrl_state_t;

endpackage

// File: common/aes_blk_if.sv
`timescale 1ns/1ps

// 128-bit block channel, valid/ready handshake
interface aes_blk_if import aes_pkg::*; ();

	logic   valid;
	logic   ready;
	block_t data;
	// block closes the packet
	logic   last;

	modport producer (output valid, output data, output last, input ready);

	modport consumer (input valid, input data, input last, output ready);

endinterface

// File: common/aes_hdr_if.sv
`timescale 1ns/1ps

// packet header from stream slave to controller
interface aes_hdr_if import aes_pkg::*; ();

	logic   valid;
	logic   cbc;
	key_t   key;
	block_t iv;
	// packet still in flight
	logic   busy;

	modport src (output valid, output cbc, output key, output iv, input busy);

	modport snk (input valid, input cbc, input key, input iv, output busy);

endinterface

// File: hw/aes_axis_slave.sv
`timescale 1ns/1ps

module aes_axis_slave import aes_pkg::*;
(
	input  logic        axis_aclk,
	input  logic        rst_n,
	input  word_t       s00_axis_tdata,
	// byte strobes are accepted and not used
	input  logic [3:0]  s00_axis_tstrb,
	input  logic        s00_axis_tvalid,
	input  logic        s00_axis_tlast,
	output logic        s00_axis_tready,
	aes_hdr_if.src      hdr,
	aes_blk_if.producer blk
);

	hdr_state_t  state;
	logic [1:0]  word_cnt;
	logic        rdy_en;
	logic [95:0] data_sr;
	logic        accept;

	// stall on a full input FIFO, and hold a new command until the old packet drains
	assign s00_axis_tready = rdy_en && !(blk.valid && !blk.ready) && !(state == S_CMD && hdr.busy);
	assign accept = s00_axis_tvalid && s00_axis_tready;

	// ======================================================================
	// parser state
	always_ff @(posedge axis_aclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= S_CMD;
			word_cnt <= '0;
			rdy_en <= 1'b0;
			hdr.valid <= 1'b0;
			blk.valid <= 1'b0;
			blk.last <= 1'b0;
		end
		else
		begin
			rdy_en <= 1'b1;
			hdr.valid <= 1'b0;
			if (blk.valid && blk.ready)
				blk.valid <= 1'b0;
			if (accept)
			begin
				case (state)
				S_CMD:
				begin
					word_cnt <= '0;
					state <= S_KEY;
				end
				S_KEY:
				begin
					word_cnt <= word_cnt + 1'b1;
					if (word_cnt == 2'd3)
						state <= S_IV;
				end
				S_IV:
				begin
					word_cnt <= word_cnt + 1'b1;
					if (word_cnt == 2'd3)
					begin
						hdr.valid <= 1'b1;
						state <= S_DATA;
					end
				end
				default:
				begin
					word_cnt <= word_cnt + 1'b1;
					if (word_cnt == 2'd3)
					begin
						blk.valid <= 1'b1;
						blk.last <= s00_axis_tlast;
					end
					if (s00_axis_tlast)
						state <= S_CMD;
				end
				endcase
			end
		end
	end

	// ======================================================================
	// header and payload shift registers, first word lands in the top bits
	always_ff @(posedge axis_aclk)
	begin
		if (accept)
		begin
			case (state)
			S_CMD:
				hdr.cbc <= s00_axis_tdata[0];
			S_KEY:
				hdr.key <= {hdr.key[95:0], s00_axis_tdata};
			S_IV:
				hdr.iv <= {hdr.iv[95:0], s00_axis_tdata};
			default:
			begin
				data_sr <= {data_sr[63:0], s00_axis_tdata};
				if (word_cnt == 2'd3)
					blk.data <= {data_sr, s00_axis_tdata};
			end
			endcase
		end
	end

	// a packet may only end inside its payload
	a_tlast_in_data: assert property (@(posedge axis_aclk) disable iff (!rst_n)
		accept && s00_axis_tlast |-> state == S_DATA);

endmodule

// File: hw/aes_block_fifo.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_block_fifo import aes_pkg::*;
#(
	parameter int DEPTH = `AES_FIFO_DEPTH
)
(
	input  logic        axis_aclk,
	input  logic        rst_n,
	aes_blk_if.consumer wr,
	aes_blk_if.producer rd
);

	localparam int PTR_W = $clog2(DEPTH);

	block_t           mem_data [DEPTH];
	logic             mem_last [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             push;
	logic             pop;

	assign wr.ready = (count != (PTR_W+1)'(DEPTH));
	assign rd.valid = (count != '0);
	assign rd.data = mem_data[rd_ptr];
	assign rd.last = mem_last[rd_ptr];
	assign push = wr.valid && wr.ready;
	assign pop = rd.valid && rd.ready;

	always_ff @(posedge axis_aclk)
	begin
		if (push)
		begin
			mem_data[wr_ptr] <= wr.data;
			mem_last[wr_ptr] <= wr.last;
		end
	end

	// pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge axis_aclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + push - pop;
		end
	end

	a_no_overflow: assert property (@(posedge axis_aclk) disable iff (!rst_n)
		count <= DEPTH);

endmodule

// File: aes_core/aes_round_core.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_round_core import aes_pkg::*;
(
	input  logic   axis_aclk,
	input  logic   rst_n,
	input  logic   start,
	input  key_t   key,
	input  block_t block_in,
	output logic   done,
	output block_t block_out
);

	// forward S-box, byte 0x00 in the top bits
	localparam logic [2047:0] SBOX_TBL = {
		256'h637c777bf26b6fc53001672bfed7ab76ca82c97dfa5947f0add4a2af9ca472c0,
		256'hb7fd9326363ff7cc34a5e5f171d8311504c723c31896059a071280e2eb27b275,
		256'h09832c1a1b6e5aa0523bd6b329e32f8453d100ed20fcb15b6acbbe394a4c58cf,
		256'hd0efaafb434d338545f9027f503c9fa851a3408f929d38f5bcb6da2110fff3d2,
		256'hcd0c13ec5f974417c4a77e3d645d197360814fdc222a908846eeb814de5e0bdb,
		256'he0323a0a4906245cc2d3ac629195e479e7c8376d8dd54ea96c56f4ea657aae08,
		256'hba78252e1ca6b4c6e8dd741f4bbd8b8a703eb5664803f60e613557b986c11d9e,
		256'he1f8981169d98e949b1e87e9ce5528df8ca1890dbfe6426841992d0fb054bb16
	};

	block_t state;
	key_t   round_key;
	round_t round;
	byte_t  rcon;
	logic   busy;
	key_t   next_key;
	block_t shifted;
	block_t mixed;

	function automatic byte_t sbox(input byte_t x);
		return SBOX_TBL[2047 - 8 * x -: 8];
	endfunction

	function automatic byte_t xtime(input byte_t x);
		return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
	endfunction

	// SubBytes and ShiftRows, bytes run down each column
	function automatic block_t sub_shift(input block_t s);
		block_t r;
		for (int c = 0; c < 4; c++)
		begin
			for (int row = 0; row < 4; row++)
			begin
				r[127 - 8 * (4 * c + row) -: 8] = sbox(s[127 - 8 * (4 * ((c + row) % 4) + row) -: 8]);
			end
		end
		return r;
	endfunction

	function automatic word_t mix_column(input word_t col);
		byte_t a0, a1, a2, a3;
		a0 = col[31:24];
		a1 = col[23:16];
		a2 = col[15:8];
		a3 = col[7:0];
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	// one step of the key schedule
	function automatic key_t expand_key(input key_t k, input byte_t rc);
		word_t t;
		word_t w0, w1, w2, w3;
		t = {sbox(k[23:16]), sbox(k[15:8]), sbox(k[7:0]), sbox(k[31:24])} ^ {rc, 24'h0};
		w0 = k[127:96] ^ t;
		w1 = k[95:64] ^ w0;
		w2 = k[63:32] ^ w1;
		w3 = k[31:0] ^ w2;
		return {w0, w1, w2, w3};
	endfunction

	always_comb
	begin
		next_key = expand_key(round_key, rcon);
		shifted = sub_shift(state);
		for (int c = 0; c < 4; c++)
			mixed[127 - 32 * c -: 32] = mix_column(shifted[127 - 32 * c -: 32]);
	end

	// ======================================================================
	// round sequencing
	always_ff @(posedge axis_aclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			round <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				round <= 4'd1;
			end
			else if (busy)
			begin
				round <= round + 1'b1;
				if (round == `AES_ROUNDS)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// start cycle is the initial AddRoundKey, MixColumns skipped in the final round
	always_ff @(posedge axis_aclk)
	begin
		if (start)
		begin
			state <= block_in ^ key;
			round_key <= key;
			rcon <= 8'h01;
		end
		else if (busy)
		begin
			state <= ((round == `AES_ROUNDS) ? shifted : mixed) ^ next_key;
			round_key <= next_key;
			rcon <= xtime(rcon);
		end
	end

	assign block_out = state;

	// single block in flight, result exactly eleven cycles later
	a_start_latency: assert property (@(posedge axis_aclk) disable iff (!rst_n)
		start |-> !busy ##11 done);

endmodule

// File: aes_core/aes_controller.sv
`timescale 1ns/1ps

module aes_controller import aes_pkg::*;
(
	input  logic        axis_aclk,
	input  logic        rst_n,
	aes_hdr_if.snk      hdr,
	aes_blk_if.consumer in_blk,
	aes_blk_if.producer out_blk,
	output logic        core_start,
	output key_t        core_key,
	output block_t      core_block,
	input  logic        core_done,
	input  block_t      core_result
);

	ctrl_state_t state;
	logic        cbc;
	block_t      chain;

	assign in_blk.ready = (state == C_FETCH);

	// ======================================================================
	// block sequencer
	always_ff @(posedge axis_aclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= C_IDLE;
			hdr.busy <= 1'b0;
			core_start <= 1'b0;
			out_blk.valid <= 1'b0;
			out_blk.last <= 1'b0;
		end
		else
		begin
			core_start <= 1'b0;
			if (hdr.valid)
				hdr.busy <= 1'b1;
			case (state)
			C_IDLE:
				if (hdr.busy)
					state <= C_FETCH;
			C_FETCH:
				if (in_blk.valid)
				begin
					core_start <= 1'b1;
					out_blk.last <= in_blk.last;
					state <= C_RUN;
				end
			C_RUN:
				if (core_done)
				begin
					out_blk.valid <= 1'b1;
					state <= C_PUSH;
				end
			default:
				if (out_blk.ready)
				begin
					out_blk.valid <= 1'b0;
					if (out_blk.last)
					begin
						hdr.busy <= 1'b0;
						state <= C_IDLE;
					end
					else
						state <= C_FETCH;
				end
			endcase
		end
	end

	// key, chaining value and core operands
	always_ff @(posedge axis_aclk)
	begin
		if (hdr.valid)
		begin
			core_key <= hdr.key;
			cbc <= hdr.cbc;
			chain <= hdr.iv;
		end
		else if (state == C_PUSH && out_blk.ready)
			chain <= out_blk.data;
		if (state == C_FETCH && in_blk.valid)
			core_block <= cbc ? in_blk.data ^ chain : in_blk.data;
		if (state == C_RUN && core_done)
			out_blk.data <= core_result;
	end

	// the core only answers a block this controller started
	a_done_in_run: assert property (@(posedge axis_aclk) disable iff (!rst_n)
		core_done |-> state == C_RUN);

endmodule

// File: hw/aes_axis_master.sv
`timescale 1ns/1ps

module aes_axis_master import aes_pkg::*;
(
	input  logic        axis_aclk,
	input  logic        rst_n,
	aes_blk_if.consumer blk,
	output word_t       m00_axis_tdata,
	output logic [3:0]  m00_axis_tstrb,
	output logic        m00_axis_tvalid,
	output logic        m00_axis_tlast,
	input  logic        m00_axis_tready
);

	block_t     hold;
	logic [1:0] beat;
	logic       last_r;
	logic       full;

	// take a new block only once the held one is fully sent
	assign blk.ready = !full;
	assign m00_axis_tvalid = full;
	// most significant word first
	assign m00_axis_tdata = hold[127 - 32 * beat -: 32];
	assign m00_axis_tstrb = '1;
	assign m00_axis_tlast = full && last_r && (beat == 2'd3);

	always_ff @(posedge axis_aclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			full <= 1'b0;
			beat <= '0;
			last_r <= 1'b0;
		end
		else if (blk.valid && blk.ready)
		begin
			full <= 1'b1;
			beat <= '0;
			last_r <= blk.last;
		end
		else if (m00_axis_tvalid && m00_axis_tready)
		begin
			beat <= beat + 1'b1;
			if (beat == 2'd3)
				full <= 1'b0;
		end
	end

	always_ff @(posedge axis_aclk)
	begin
		if (blk.valid && blk.ready)
			hold <= blk.data;
	end

endmodule

// File: hw/zynq_aes_top.sv
`timescale 1ns/1ps

module zynq_aes_top import aes_pkg::*;
(
	input  logic       axis_aclk,
	input  logic       rst_n,
	input  word_t      s00_axis_tdata,
	input  logic [3:0] s00_axis_tstrb,
	input  logic       s00_axis_tvalid,
	input  logic       s00_axis_tlast,
	output logic       s00_axis_tready,
	output word_t      m00_axis_tdata,
	output logic [3:0] m00_axis_tstrb,
	output logic       m00_axis_tvalid,
	output logic       m00_axis_tlast,
	input  logic       m00_axis_tready
);

	aes_hdr_if hdr_bus ();
	aes_blk_if slv_blk ();
	aes_blk_if ctl_in_blk ();
	aes_blk_if ctl_out_blk ();
	aes_blk_if mst_blk ();

	logic   core_start;
	key_t   core_key;
	block_t core_block;
	logic   core_done;
	block_t core_result;

	// ======================================================================
	// input side
	aes_axis_slave u_slave (
		.axis_aclk      (axis_aclk),
		.rst_n          (rst_n),
		.s00_axis_tdata (s00_axis_tdata),
		.s00_axis_tstrb (s00_axis_tstrb),
		.s00_axis_tvalid(s00_axis_tvalid),
		.s00_axis_tlast (s00_axis_tlast),
		.s00_axis_tready(s00_axis_tready),
		.hdr            (hdr_bus),
		.blk            (slv_blk)
	);

	aes_block_fifo u_in_fifo (.axis_aclk(axis_aclk), .rst_n(rst_n), .wr(slv_blk), .rd(ctl_in_blk));

	// ======================================================================
	// cipher
	aes_controller u_controller (
		.axis_aclk  (axis_aclk),
		.rst_n      (rst_n),
		.hdr        (hdr_bus),
		.in_blk     (ctl_in_blk),
		.out_blk    (ctl_out_blk),
		.core_start (core_start),
		.core_key   (core_key),
		.core_block (core_block),
		.core_done  (core_done),
		.core_result(core_result)
	);

	aes_round_core u_core (
		.axis_aclk(axis_aclk),
		.rst_n    (rst_n),
		.start    (core_start),
		.key      (core_key),
		.block_in (core_block),
		.done     (core_done),
		.block_out(core_result)
	);

	// ======================================================================
	// output side
	aes_block_fifo u_out_fifo (.axis_aclk(axis_aclk), .rst_n(rst_n), .wr(ctl_out_blk), .rd(mst_blk));

	aes_axis_master u_master (
		.axis_aclk      (axis_aclk),
		.rst_n          (rst_n),
		.blk            (mst_blk),
		.m00_axis_tdata (m00_axis_tdata),
		.m00_axis_tstrb (m00_axis_tstrb),
		.m00_axis_tvalid(m00_axis_tvalid),
		.m00_axis_tlast (m00_axis_tlast),
		.m00_axis_tready(m00_axis_tready)
	);

endmodule

// File: verification/aes_model.svh
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// reference AES-128, filled by build_model_sbox before first use
byte_t model_sbox [256];

// GF(2^8) product modulo x^8 + x^4 + x^3 + x + 1
function automatic byte_t gf_mul(input byte_t a, input byte_t b);
	byte_t p;
	byte_t x;
	p = 8'h00;
	x = a;
	for (int i = 0; i < 8; i++)
	begin
		if (b[i])
			p = p ^ x;
		x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
	end
	return p;
endfunction

// multiplicative inverse by search, then the affine map
task automatic build_model_sbox();
	byte_t inv;
	byte_t b;
	for (int x = 0; x < 256; x++)
	begin
		inv = 8'h00;
		for (int y = 1; y < 256; y++)
			if (gf_mul(byte_t'(x), byte_t'(y)) == 8'h01)
				inv = byte_t'(y);
		b = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
			^ {inv[3:0], inv[7:4]};
		model_sbox[x] = b ^ 8'h63;
	end
endtask

// state byte i sits at row i%4, column i/4
function automatic block_t aes128_encrypt(input key_t key, input block_t pt);
	byte_t  s [16];
	byte_t  t [16];
	byte_t  rk [16];
	byte_t  g [4];
	byte_t  rc;
	block_t ct;
	for (int i = 0; i < 16; i++)
	begin
		rk[i] = key[127 - 8 * i -: 8];
		s[i] = pt[127 - 8 * i -: 8] ^ rk[i];
	end
	rc = 8'h01;
	for (int rnd = 1; rnd <= 10; rnd++)
	begin
		// key schedule, last word rotated and substituted
		g[0] = model_sbox[rk[13]] ^ rc;
		g[1] = model_sbox[rk[14]];
		g[2] = model_sbox[rk[15]];
		g[3] = model_sbox[rk[12]];
		for (int i = 0; i < 4; i++)
			rk[i] = rk[i] ^ g[i];
		for (int i = 4; i < 16; i++)
			rk[i] = rk[i] ^ rk[i - 4];
		rc = gf_mul(rc, 8'h02);
		// row r moves left by r columns
		for (int i = 0; i < 16; i++)
			t[i] = model_sbox[s[4 * ((i / 4 + i % 4) % 4) + i % 4]];
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				if (rnd < 10)
					s[4 * c + r] = gf_mul(t[4 * c + r], 8'h02)
						^ gf_mul(t[4 * c + (r + 1) % 4], 8'h03)
						^ t[4 * c + (r + 2) % 4] ^ t[4 * c + (r + 3) % 4];
				else
					s[4 * c + r] = t[4 * c + r];
		for (int i = 0; i < 16; i++)
			s[i] = s[i] ^ rk[i];
	end
	for (int i = 0; i < 16; i++)
		ct[127 - 8 * i -: 8] = s[i];
	return ct;
endfunction

// one CBC step, previous ciphertext masks the plaintext
function automatic block_t cbc_chain(input key_t key, input block_t prev, input block_t pt);
	return aes128_encrypt(key, pt ^ prev);
endfunction

`endif

// File: verification/tb_zynq_aes_top.sv
`timescale 1ns/1ps

module tb_zynq_aes_top import aes_pkg::*;
();

	localparam int ECB_BLOCKS = 8;
	localparam int CBC_BLOCKS = 6;
	// more than both FIFOs hold together
	localparam int BP_BLOCKS = 40;
	// three back to back packets of 3, 2 and 5 blocks
	localparam int MULTI_BLOCKS = 10;
	localparam int TOTAL_BLOCKS = 1 + ECB_BLOCKS + CBC_BLOCKS + BP_BLOCKS + MULTI_BLOCKS;
	localparam int MAX_CYCLES = 200 * TOTAL_BLOCKS + 1000;

	localparam key_t   KAT_KEY = 128'h000102030405060708090a0b0c0d0e0f;
	localparam block_t KAT_PT = 128'h00112233445566778899aabbccddeeff;
	localparam block_t KAT_CT = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

	logic       axis_aclk;
	logic       rst_n;
	word_t      s00_axis_tdata;
	logic [3:0] s00_axis_tstrb;
	logic       s00_axis_tvalid;
	logic       s00_axis_tlast;
	logic       s00_axis_tready;
	word_t      m00_axis_tdata;
	logic [3:0] m00_axis_tstrb;
	logic       m00_axis_tvalid;
	logic       m00_axis_tlast;
	logic       m00_axis_tready;

	word_t exp_words [$];
	logic  exp_last [$];
	word_t stim_state;
	word_t rdy_state;
	logic  back_pressure;
	int    cycles;

	`include "aes_model.svh"

	zynq_aes_top u_dut (
		.axis_aclk      (axis_aclk),
		.rst_n          (rst_n),
		.s00_axis_tdata (s00_axis_tdata),
		.s00_axis_tstrb (s00_axis_tstrb),
		.s00_axis_tvalid(s00_axis_tvalid),
		.s00_axis_tlast (s00_axis_tlast),
		.s00_axis_tready(s00_axis_tready),
		.m00_axis_tdata (m00_axis_tdata),
		.m00_axis_tstrb (m00_axis_tstrb),
		.m00_axis_tvalid(m00_axis_tvalid),
		.m00_axis_tlast (m00_axis_tlast),
		.m00_axis_tready(m00_axis_tready)
	);

	always #5 axis_aclk = ~axis_aclk;

	function automatic word_t xorshift32(inout word_t st);
		st = st ^ (st << 13);
		st = st ^ (st >> 17);
		st = st ^ (st << 5);
		return st;
	endfunction

	function automatic block_t rand_block();
		block_t b;
		b = '0;
		for (int w = 0; w < 4; w++)
			b = {b[95:0], xorshift32(stim_state)};
		return b;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	// ======================================================================
	// checks
	task automatic check_word(input word_t got, input word_t exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: m00_axis_tdata is %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_last(input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: m00_axis_tlast is %b, expected %b",
				$time, got, exp));
	endtask

	task automatic check_strb(input logic [3:0] got);
		if (got !== 4'hf)
			abort_run($sformatf("Error at %0t: m00_axis_tstrb is %h, expected f", $time, got));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	// ======================================================================
	// stimulus
	task automatic send_word(input word_t w, input logic last, input logic rand_strb);
		word_t r;
		r = xorshift32(stim_state);
		s00_axis_tdata = w;
		s00_axis_tlast = last;
		s00_axis_tstrb = rand_strb ? r[3:0] : 4'hf;
		s00_axis_tvalid = 1'b1;
		do
			@(posedge axis_aclk);
		while (!s00_axis_tready);
		#1;
	endtask

	// expected words are queued before the packet goes out
	task automatic send_packet(input logic cbc, input key_t key, input block_t iv,
		input block_t pt [$], input logic rand_strb);
		block_t chain;
		block_t ct;
		chain = iv;
		foreach (pt[i])
		begin
			ct = cbc ? cbc_chain(key, chain, pt[i]) : aes128_encrypt(key, pt[i]);
			chain = ct;
			for (int w = 0; w < 4; w++)
			begin
				exp_words.push_back(ct[127 - 32 * w -: 32]);
				exp_last.push_back(i == pt.size() - 1 && w == 3);
			end
		end
		send_word({31'h0, cbc}, 1'b0, rand_strb);
		for (int w = 0; w < 4; w++)
			send_word(key[127 - 32 * w -: 32], 1'b0, rand_strb);
		for (int w = 0; w < 4; w++)
			send_word(iv[127 - 32 * w -: 32], 1'b0, rand_strb);
		foreach (pt[i])
			for (int w = 0; w < 4; w++)
				send_word(pt[i][127 - 32 * w -: 32], i == pt.size() - 1 && w == 3, rand_strb);
		s00_axis_tvalid = 1'b0;
		s00_axis_tlast = 1'b0;
	endtask

	task automatic run_random(input logic cbc, input int nblocks, input logic rand_strb);
		block_t pt [$];
		key_t   key;
		block_t iv;
		key = rand_block();
		iv = rand_block();
		for (int i = 0; i < nblocks; i++)
			pt.push_back(rand_block());
		send_packet(cbc, key, iv, pt, rand_strb);
	endtask

	task automatic wait_drain();
		do
			@(posedge axis_aclk);
		while (exp_words.size() != 0);
		#1;
	endtask

	// output sink with 30% ready under back-pressure
	always @(posedge axis_aclk)
	begin
		#1;
		if (back_pressure)
			m00_axis_tready = (xorshift32(rdy_state) % 100) < 30;
		else
			m00_axis_tready = 1'b1;
	end

	// ======================================================================
	// compare every output beat against the queue
	always @(posedge axis_aclk)
	begin
		if (rst_n && m00_axis_tvalid && m00_axis_tready)
		begin
			if (exp_words.size() == 0)
				abort_run("output beat arrived while no word was expected");
			else
			begin
				check_word(m00_axis_tdata, exp_words.pop_front());
				check_last(m00_axis_tlast, exp_last.pop_front());
				check_strb(m00_axis_tstrb);
			end
		end
	end

	always @(posedge axis_aclk)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
			abort_run($sformatf("Timeout after %0d cycles, output never completed", cycles));
	end

	initial
	begin
		block_t pt [$];
		axis_aclk = 1'b0;
		rst_n = 1'b0;
		s00_axis_tdata = '0;
		s00_axis_tstrb = 4'hf;
		s00_axis_tvalid = 1'b0;
		s00_axis_tlast = 1'b0;
		m00_axis_tready = 1'b0;
		back_pressure = 1'b0;
		stim_state = 32'd43;
		rdy_state = 32'd43;
		cycles = 0;
		build_model_sbox();
		if (aes128_encrypt(KAT_KEY, KAT_PT) !== KAT_CT)
			abort_run("reference model does not give the known answer ciphertext");
		repeat (16) @(posedge axis_aclk);
		#1;
		// outputs held low in reset
		check_flag("s00_axis_tready", s00_axis_tready, 1'b0);
		check_flag("m00_axis_tvalid", m00_axis_tvalid, 1'b0);
		check_flag("m00_axis_tlast", m00_axis_tlast, 1'b0);
		rst_n = 1'b1;
		@(posedge axis_aclk);
		#1;
		// ready from the first cycle after reset
		check_flag("s00_axis_tready", s00_axis_tready, 1'b1);

		// known answer followed by random ECB and CBC
		pt.push_back(KAT_PT);
		send_packet(1'b0, KAT_KEY, '0, pt, 1'b0);
		run_random(1'b0, ECB_BLOCKS, 1'b0);
		run_random(1'b1, CBC_BLOCKS, 1'b0);
		wait_drain();

		back_pressure = 1'b1;
		run_random(1'b0, BP_BLOCKS, 1'b0);
		wait_drain();
		back_pressure = 1'b0;

		// back to back packets with the header held off by busy
		run_random(1'b1, 3, 1'b1);
		run_random(1'b0, 2, 1'b1);
		run_random(1'b1, 5, 1'b1);
		wait_drain();
		repeat (20) @(posedge axis_aclk);
		#1;

		if (s00_axis_tready === 1'b1 && m00_axis_tvalid === 1'b0)
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
			abort_run("DUT did not return to idle after the last packet");
	end

endmodule

// File: filelist.f
+incdir+common
+incdir+verification
common/aes_pkg.sv
common/aes_blk_if.sv
common/aes_hdr_if.sv
hw/aes_axis_slave.sv
hw/aes_block_fifo.sv
aes_core/aes_round_core.sv
aes_core/aes_controller.sv
hw/aes_axis_master.sv
hw/zynq_aes_top.sv
verification/tb_zynq_aes_top.sv
